/* pce_bridge.f */
+incdir+design
design/pce_bridge_pkg.sv
design/bridge_decode.sv
design/settings_regs.sv
design/control_router.sv
design/bridge_readback.sv
design/pce_bridge_top.sv
tb/tb_pce_bridge.sv

/* tb/pce_bridge_golden.txt */
# kind name fields, hex: Z | W addr data settings cart save sgx | A data cfg | R addr rd
# P cont_type assign count | C latency hold | B addr1 data1 addr2 data2 settings
Z reset_state
W turbo_tap 00000100 00000001 1000 0 0 0
W button6 00000104 00000001 1800 0 0 0
W b1_speed 00000108 00000003 1E00 0 0 0
W b2_speed 0000010C 00000002 1F00 0 0 0
W overscan 00000200 00000001 1F40 0 0 0
W extra_sprites 00000204 00000001 1F60 0 0 0
W raw_rgb 00000208 00000001 1F70 0 0 0
W master_boost 00000300 00000002 1F78 0 0 0
W adpcm_boost 00000304 00000001 1F7A 0 0 0
W cd_boost 00000308 00000001 1F7B 0 0 0
W cart_download 00000000 00000001 1F7B 1 0 0
W save_download 00000004 00000001 1F7B 1 1 0
W sgx_flag 00000008 00000001 1F7B 1 1 1
W unmapped_write 00001234 0000FFFF 1F7B 1 1 1
A analogizer_word FFFFE963 35A
R read_analogizer F7000000 00002963
R read_other_addr 00000100 00000000
P route_type_zero 0 4 8
P route_assign_0 1 0 8
P route_assign_1 3 1 8
P route_assign_2 1 2 8
P route_assign_3 1F 3 8
P route_assign_4 2 4 8
P route_assign_5 1 5 8
P route_assign_6 4 6 8
P route_assign_7 1 7 8
C core_reset_hold 2 100
B back_to_back 00000200 00000000 00000304 00000000 1F39

/* tb/tb_pce_bridge.sv */
/*
  testbench of the bridge control block: clock and reset,
  golden record reader, write, read, routing and reset tests
*/

`timescale 1ns/1ps
`default_nettype none

`include "pce_bridge_config.svh"

module tb_pce_bridge;

  import pce_bridge_pkg::*;

  localparam int WAIT_LIMIT = 1000;

  logic            clk_74a;
  logic            pll_core_locked;
  logic [31:0]     bridge_addr;
  logic            bridge_wr;
  logic [31:0]     bridge_wr_data;
  players_t        pocket_pads;
  players_t        snac_pads;
  logic [31:0]     bridge_rd_data;
  pce_settings_t   settings;
  logic            cart_download;
  logic            save_download;
  logic            is_sgx;
  analogizer_cfg_t snac_cfg;
  players_t        players;
  logic            core_reset;

  integer fd;
  integer seed;
  integer err_count;
  integer tests_run;
  integer tests_failed;
  logic   timed_out;

  pce_bridge_top DUT (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .pocket_pads     (pocket_pads),
    .snac_pads       (snac_pads),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings),
    .cart_download   (cart_download),
    .save_download   (save_download),
    .is_sgx          (is_sgx),
    .snac_cfg        (snac_cfg),
    .players         (players),
    .core_reset      (core_reset)
  );

  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task check_settings(input string name, input pce_settings_t exp, input pce_settings_t act);
    if (act !== exp) begin
      $display("Mismatch %s settings: expected %h, actual %h", name, exp, act);
      err_count = err_count + 1;
    end
  endtask

  task check_players(input string name, input players_t exp, input players_t act);
    if (act !== exp) begin
      $display("Mismatch %s players: expected %h, actual %h", name, exp, act);
      err_count = err_count + 1;
    end
  endtask

  task check_cfg(input string name, input analogizer_cfg_t exp, input analogizer_cfg_t act);
    if (act !== exp) begin
      $display("Mismatch %s snac_cfg: expected %h, actual %h", name, exp, act);
      err_count = err_count + 1;
    end
  endtask

  task check_word(input string name, input string field, input logic [31:0] exp,
                  input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h, actual %h", name, field, exp, act);
      err_count = err_count + 1;
    end
  endtask

  task check_flag(input string name, input string field, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %b, actual %b", name, field, exp, act);
      err_count = err_count + 1;
    end
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // one-cycle write, returns just after the edge that samples it
  task drive_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr      <= 1'b0;
  endtask

  // routing model of the snac assignment table
  function automatic players_t predict_route(input logic [4:0] ctype, input logic [3:0] asg,
                                             input players_t pk, input players_t sn);
    players_t r;
    r = pk;
    if (ctype != 5'd0) begin
      if (asg == 4'd0) r.p1 = sn.p1;
      if (asg == 4'd1) r.p2 = sn.p1;
      if (asg == 4'd2) begin
        r.p1 = sn.p1;
        r.p2 = sn.p2;
      end
      if (asg == 4'd3) begin
        r.p1 = sn.p2;
        r.p2 = sn.p1;
      end
      if (asg == 4'd4) r = sn;
      if (asg == 4'd5) r = {sn.p4, sn.p3, sn.p2, sn.p1};
      if (asg == 4'd6) begin
        r.p3 = sn.p1;
        r.p4 = sn.p2;
      end
    end
    return r;
  endfunction

  task skip_line;
    integer c;
    c = $fgetc(fd);
    while (c != "\n" && c != -1) c = $fgetc(fd);
  endtask

  //////////////////////////////
  // golden record runner
  //////////////////////////////

  task run_record(input string kind);
    string       name;
    integer      code;
    integer      errs_before;
    integer      i;
    integer      cycles;
    logic [31:0] a1, d1, a2, d2, v1, f1, f2, f3;
    players_t    pk, sn;
    errs_before = err_count;
    code = $fscanf(fd, "%s", name);
    case (kind)
      "Z": begin
        @(negedge clk_74a);
        check_settings(name, '0, settings);
        check_flag(name, "cart_download", 1'b0, cart_download);
        check_flag(name, "save_download", 1'b0, save_download);
        check_flag(name, "is_sgx", 1'b0, is_sgx);
        check_flag(name, "core_reset", 1'b0, core_reset);
        check_cfg(name, '0, snac_cfg);
        check_players(name, '0, players);
        check_word(name, "bridge_rd_data", 32'd0, bridge_rd_data);
      end
      "W": begin
        code = $fscanf(fd, "%h %h %h %h %h %h", a1, d1, v1, f1, f2, f3);
        drive_write(a1, d1);
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_settings(name, pce_settings_t'(v1[12:0]), settings);
        check_flag(name, "cart_download", f1[0], cart_download);
        check_flag(name, "save_download", f2[0], save_download);
        check_flag(name, "is_sgx", f3[0], is_sgx);
      end
      "A": begin
        code = $fscanf(fd, "%h %h", d1, v1);
        drive_write(`PCE_ADDR_ANALOGIZER, d1);
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_cfg(name, analogizer_cfg_t'(v1[12:0]), snac_cfg);
      end
      "R": begin
        code = $fscanf(fd, "%h %h", a1, v1);
        @(posedge clk_74a);
        bridge_addr <= a1;
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_word(name, "bridge_rd_data", v1, bridge_rd_data);
      end
      "P": begin
        code = $fscanf(fd, "%h %h %h", f1, f2, a1);
        drive_write(`PCE_ADDR_ANALOGIZER, {22'd0, f2[3:0], 1'b0, f1[4:0]});
        for (i = 0; i < a1; i = i + 1) begin
          pk = {$random(seed), $random(seed)};
          sn = {$random(seed), $random(seed)};
          @(posedge clk_74a);
          pocket_pads <= pk;
          snac_pads   <= sn;
          @(posedge clk_74a);
          @(negedge clk_74a);
          check_players(name, predict_route(f1[4:0], f2[3:0], pk, sn), players);
        end
      end
      "C": begin
        code = $fscanf(fd, "%h %h", v1, d1);
        drive_write(`PCE_ADDR_CORE_RESET, 32'd1);
        // latency counted from the edge that drove the write
        cycles = 1;
        while (core_reset !== 1'b1 && cycles < 16) begin
          @(posedge clk_74a);
          cycles = cycles + 1;
          @(negedge clk_74a);
        end
        if (core_reset !== 1'b1) begin
          $display("%s: core_reset did not rise within 16 cycles", name);
          err_count = err_count + 1;
          timed_out = 1'b1;
        end else begin
          check_word(name, "core_reset latency", v1, cycles);
          cycles = 0;
          while (core_reset === 1'b1 && cycles < WAIT_LIMIT) begin
            cycles = cycles + 1;
            @(negedge clk_74a);
          end
          if (cycles >= WAIT_LIMIT) begin
            $display("%s: core_reset stayed high past %0d cycles", name, WAIT_LIMIT);
            err_count = err_count + 1;
            timed_out = 1'b1;
          end else begin
            check_word(name, "core_reset hold", d1, cycles);
          end
        end
      end
      "B": begin
        code = $fscanf(fd, "%h %h %h %h %h", a1, d1, a2, d2, v1);
        @(posedge clk_74a);
        bridge_addr    <= a1;
        bridge_wr_data <= d1;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_addr    <= a2;
        bridge_wr_data <= d2;
        @(posedge clk_74a);
        bridge_wr      <= 1'b0;
        @(posedge clk_74a);
        @(negedge clk_74a);
        check_settings(name, pce_settings_t'(v1[12:0]), settings);
      end
      default: begin
        $display("unknown record kind %s in the golden file", kind);
        err_count = err_count + 1;
      end
    endcase
    tests_run = tests_run + 1;
    if (err_count == errs_before) begin
      $display("ok      %s", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("failed  %s", name);
    end
  endtask

  initial begin
    string  tok;
    integer code;
    logic   done;
    seed            = 31;
    err_count       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    timed_out       = 1'b0;
    done            = 1'b0;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    pocket_pads     = '0;
    snac_pads       = '0;
    repeat (3) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    fd = $fopen("tb/pce_bridge_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file tb/pce_bridge_golden.txt");
      err_count = err_count + 1;
    end else begin
      while (!done && !timed_out) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) done = 1'b1;
        else if (tok[0] == "#") skip_line();
        else run_record(tok);
      end
      $fclose(fd);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/pce_bridge_top.sv */
/*
  bridge control block top: decode, settings and routing,
  readback of the analogizer word
*/

`timescale 1ns/1ps
`default_nettype none

module pce_bridge_top (
  input  wire                             clk_74a,
  input  wire                             pll_core_locked,
  input  wire  [31:0]                     bridge_addr,
  input  wire                             bridge_wr,
  input  wire  [31:0]                     bridge_wr_data,
  input  wire pce_bridge_pkg::players_t   pocket_pads,
  input  wire pce_bridge_pkg::players_t   snac_pads,
  output logic [31:0]                     bridge_rd_data,
  output pce_bridge_pkg::pce_settings_t   settings,
  output logic                            cart_download,
  output logic                            save_download,
  output logic                            is_sgx,
  output pce_bridge_pkg::analogizer_cfg_t snac_cfg,
  output pce_bridge_pkg::players_t        players,
  output logic                            core_reset
);

  import pce_bridge_pkg::*;

  bridge_cmd_t cmd;
  logic        cmd_valid;
  logic [13:0] snac_word;

  // decode step
  bridge_decode u_decode (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_wr       (bridge_wr),
    .bridge_addr     (bridge_addr),
    .bridge_wr_data  (bridge_wr_data),
    .cmd             (cmd),
    .cmd_valid       (cmd_valid)
  );

  // execute step
  settings_regs u_settings (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cmd             (cmd),
    .cmd_valid       (cmd_valid),
    .settings        (settings),
    .cart_download   (cart_download),
    .save_download   (save_download),
    .is_sgx          (is_sgx),
    .snac_cfg        (snac_cfg),
    .snac_word       (snac_word),
    .core_reset      (core_reset)
  );

  control_router u_router (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .snac_cfg        (snac_cfg),
    .pocket_pads     (pocket_pads),
    .snac_pads       (snac_pads),
    .players         (players)
  );

  // result step
  bridge_readback u_readback (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .snac_word       (snac_word),
    .bridge_rd_data  (bridge_rd_data)
  );

endmodule

`default_nettype wire

/* design/bridge_readback.sv */
/*
  bridge read data mux, returns the analogizer word
  and zero for every other address
*/

`timescale 1ns/1ps
`default_nettype none

`include "pce_bridge_config.svh"

module bridge_readback (
  input  wire         clk_74a,
  input  wire         pll_core_locked,
  input  wire  [31:0] bridge_addr,
  input  wire  [13:0] snac_word,
  output logic [31:0] bridge_rd_data
);

  logic addr_hit;

  // only the analogizer word is readable here
  assign addr_hit = (bridge_addr == `PCE_ADDR_ANALOGIZER);

  ///////////////////////////////
  // read register
  ///////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      bridge_rd_data <= '0;
    end else if (addr_hit) begin
      bridge_rd_data <= {18'd0, snac_word};
    end else begin
      bridge_rd_data <= '0;
    end
  end

  // host sees a zero-extended 14-bit word
  a_upper_zero : assert property (
    @(posedge clk_74a)
    bridge_rd_data[31:14] == 18'd0
  );

endmodule

`default_nettype wire

/* design/control_router.sv */
/*
  player input routing between handheld pads and SNAC pads,
  selected by the analogizer controller type and assignment
*/

`timescale 1ns/1ps
`default_nettype none

module control_router (
  input  wire                             clk_74a,
  input  wire                             pll_core_locked,
  input  wire pce_bridge_pkg::analogizer_cfg_t snac_cfg,
  input  wire pce_bridge_pkg::players_t   pocket_pads,
  input  wire pce_bridge_pkg::players_t   snac_pads,
  output pce_bridge_pkg::players_t        players
);

  import pce_bridge_pkg::*;

  players_t routed;

  ///////////////////////////////
  // routing table
  ///////////////////////////////

  always_comb begin
    // unnamed players keep their handheld pad
    routed = pocket_pads;
    if (snac_cfg.cont_type != 5'd0) begin
      case (snac_cfg.cont_assign)
        4'd0: begin
          routed.p1 = snac_pads.p1;
        end
        4'd1: begin
          routed.p2 = snac_pads.p1;
        end
        4'd2: begin
          routed.p1 = snac_pads.p1;
          routed.p2 = snac_pads.p2;
        end
        4'd3: begin
          // swapped pair
          routed.p1 = snac_pads.p2;
          routed.p2 = snac_pads.p1;
        end
        4'd4: begin
          routed = snac_pads;
        end
        4'd5: begin
          routed.p1 = snac_pads.p4;
          routed.p2 = snac_pads.p3;
          routed.p3 = snac_pads.p2;
          routed.p4 = snac_pads.p1;
        end
        4'd6: begin
          // multitap, snac on the last two ports
          routed.p3 = snac_pads.p1;
          routed.p4 = snac_pads.p2;
        end
        default: begin
          routed = pocket_pads;
        end
      endcase
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      players <= '0;
    end else begin
      players <= routed;
    end
  end

endmodule

`default_nettype wire

/* design/settings_regs.sv */
/*
  execute stage for bridge writes: core settings, download
  flags, analogizer word and its split fields, core reset
  hold counter
*/

`timescale 1ns/1ps
`default_nettype none

`include "pce_bridge_config.svh"

module settings_regs (
  input  wire                             clk_74a,
  input  wire                             pll_core_locked,
  input  wire pce_bridge_pkg::bridge_cmd_t cmd,
  input  wire                             cmd_valid,
  output pce_bridge_pkg::pce_settings_t   settings,
  output logic                            cart_download,
  output logic                            save_download,
  output logic                            is_sgx,
  output pce_bridge_pkg::analogizer_cfg_t snac_cfg,
  output logic [13:0]                     snac_word,
  output logic                            core_reset
);

  import pce_bridge_pkg::*;

  logic [`PCE_RESET_CNT_W-1:0] hold_cnt;
  logic [`PCE_RESET_CNT_W-1:0] hold_next;

  // reset hold, a new request restarts the count
  always_comb begin
    hold_next = hold_cnt;
    if (hold_cnt != '0) begin
      hold_next = hold_cnt - 1'b1;
    end
    if (cmd_valid && cmd.op == OP_CORE_RESET) begin
      hold_next = `PCE_RESET_CNT_W'(`PCE_RESET_HOLD);
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt   <= '0;
      core_reset <= 1'b0;
    end else begin
      hold_cnt   <= hold_next;
      core_reset <= (hold_next != '0);
    end
  end

  ///////////////////////////////
  // register file
  ///////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings      <= '0;
      cart_download <= 1'b0;
      save_download <= 1'b0;
      is_sgx        <= 1'b0;
      snac_word     <= '0;
      snac_cfg      <= '0;
    end else if (cmd_valid) begin
      case (cmd.op)
        OP_CART_DL:       cart_download          <= cmd.payload[0];
        OP_SAVE_DL:       save_download          <= cmd.payload[0];
        OP_SGX:           is_sgx                 <= cmd.payload[0];
        OP_TURBO_TAP:     settings.turbo_tap     <= cmd.payload[0];
        OP_BUTTON6:       settings.button6       <= cmd.payload[0];
        OP_B1_SPEED:      settings.b1_speed      <= cmd.payload[1:0];
        OP_B2_SPEED:      settings.b2_speed      <= cmd.payload[1:0];
        OP_OVERSCAN:      settings.overscan      <= cmd.payload[0];
        OP_EXTRA_SPRITES: settings.extra_sprites <= cmd.payload[0];
        OP_RAW_RGB:       settings.raw_rgb       <= cmd.payload[0];
        OP_MASTER_BOOST:  settings.master_boost  <= cmd.payload[1:0];
        OP_ADPCM_BOOST:   settings.adpcm_boost   <= cmd.payload[0];
        OP_CD_BOOST:      settings.cd_boost      <= cmd.payload[0];
        OP_ANALOGIZER: begin
          snac_word            <= cmd.payload;
          // split fields for the snac router and video path
          snac_cfg.cont_type   <= cmd.payload[`PCE_SNAC_TYPE_LSB +: 5];
          snac_cfg.cont_assign <= cmd.payload[`PCE_SNAC_ASSIGN_LSB +: 4];
          snac_cfg.video_type  <= cmd.payload[`PCE_VIDEO_TYPE_LSB +: 4];
        end
        default: ;
      endcase
    end
  end

  // counter can never run above its reload value
  a_hold_bound : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    core_reset |-> hold_cnt <= `PCE_RESET_HOLD
  );

endmodule

`default_nettype wire

/* design/bridge_decode.sv */
/*
  bridge write decoder that maps a write address to an opcode
  and registers opcode, payload and a one-cycle strobe
*/

`timescale 1ns/1ps
`default_nettype none

`include "pce_bridge_config.svh"

module bridge_decode (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire                         bridge_wr,
  input  wire [31:0]                  bridge_addr,
  input  wire [31:0]                  bridge_wr_data,
  output pce_bridge_pkg::bridge_cmd_t cmd,
  output logic                        cmd_valid
);

  import pce_bridge_pkg::*;

  bridge_op_e op_next;

  // address map lookup
  always_comb begin
    case (bridge_addr)
      `PCE_ADDR_CART_DL:       op_next = OP_CART_DL;
      `PCE_ADDR_SAVE_DL:       op_next = OP_SAVE_DL;
      `PCE_ADDR_SGX:           op_next = OP_SGX;
      `PCE_ADDR_CORE_RESET:    op_next = OP_CORE_RESET;
      `PCE_ADDR_TURBO_TAP:     op_next = OP_TURBO_TAP;
      `PCE_ADDR_BUTTON6:       op_next = OP_BUTTON6;
      `PCE_ADDR_B1_SPEED:      op_next = OP_B1_SPEED;
      `PCE_ADDR_B2_SPEED:      op_next = OP_B2_SPEED;
      `PCE_ADDR_OVERSCAN:      op_next = OP_OVERSCAN;
      `PCE_ADDR_EXTRA_SPRITES: op_next = OP_EXTRA_SPRITES;
      `PCE_ADDR_RAW_RGB:       op_next = OP_RAW_RGB;
      `PCE_ADDR_MASTER_BOOST:  op_next = OP_MASTER_BOOST;
      `PCE_ADDR_ADPCM_BOOST:   op_next = OP_ADPCM_BOOST;
      `PCE_ADDR_CD_BOOST:      op_next = OP_CD_BOOST;
      `PCE_ADDR_ANALOGIZER:    op_next = OP_ANALOGIZER;
      default:                 op_next = OP_NONE;
    endcase
  end

  ///////////////////////////////
  // strobe
  ///////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= bridge_wr && (op_next != OP_NONE);
    end
  end

  // opcode and payload of the last write
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cmd <= '0;
    end else if (bridge_wr) begin
      cmd.op      <= op_next;
      cmd.payload <= bridge_wr_data[13:0];
    end
  end

  // unmapped writes must never leak a strobe
  a_no_empty_strobe : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    cmd_valid |-> cmd.op != OP_NONE
  );

endmodule

`default_nettype wire

/* design/pce_bridge_pkg.sv */
/*
  shared types of the bridge control block:
  write opcode enum, decoded command, core settings,
  Analogizer fields, pad and player bundles
*/

`default_nettype none

package pce_bridge_pkg;

  // one opcode per writable bridge register
  typedef enum logic [3:0] {
    OP_NONE,
    OP_CART_DL,
    OP_SAVE_DL,
    OP_SGX,
    OP_CORE_RESET,
    OP_TURBO_TAP,
    OP_BUTTON6,
    OP_B1_SPEED,
    OP_B2_SPEED,
    OP_OVERSCAN,
    OP_EXTRA_SPRITES,
    OP_RAW_RGB,
    OP_MASTER_BOOST,
    OP_ADPCM_BOOST,
    OP_CD_BOOST,
    OP_ANALOGIZER
  } bridge_op_e;

  // decoded write, payload is the low part of the write data
  typedef struct packed {
    bridge_op_e  op;
    logic [13:0] payload;
  } bridge_cmd_t;

  // core settings, 13 bits
  typedef struct packed {
    logic       turbo_tap;
    logic       button6;
    logic [1:0] b1_speed;
    logic [1:0] b2_speed;
    logic       overscan;
    logic       extra_sprites;
    logic       raw_rgb;
    logic [1:0] master_boost;
    logic       adpcm_boost;
    logic       cd_boost;
  } pce_settings_t;

  // fields of the analogizer word
  typedef struct packed {
    logic [4:0] cont_type;
    logic [3:0] cont_assign;
    logic [3:0] video_type;
  } analogizer_cfg_t;

  // key bitmap, dpad in [3:0], face a/b in [5:4], select/start in [15:14]
  typedef logic [15:0] pad_t;

  typedef struct packed {
    pad_t p1;
    pad_t p2;
    pad_t p3;
    pad_t p4;
  } players_t;

endpackage

`default_nettype wire

/* design/pce_bridge_config.svh */
/*
  bridge register map of the PC Engine core,
  core reset hold count and its counter width,
  bit positions of the Analogizer settings word
*/

`ifndef PCE_BRIDGE_CONFIG_SVH
`define PCE_BRIDGE_CONFIG_SVH

// download and system flags
`define PCE_ADDR_CART_DL       32'h0000_0000
`define PCE_ADDR_SAVE_DL       32'h0000_0004
`define PCE_ADDR_SGX           32'h0000_0008
`define PCE_ADDR_CORE_RESET    32'h0000_0050

// controller options
`define PCE_ADDR_TURBO_TAP     32'h0000_0100
`define PCE_ADDR_BUTTON6       32'h0000_0104
`define PCE_ADDR_B1_SPEED      32'h0000_0108
`define PCE_ADDR_B2_SPEED      32'h0000_010C

// video options
`define PCE_ADDR_OVERSCAN      32'h0000_0200
`define PCE_ADDR_EXTRA_SPRITES 32'h0000_0204
`define PCE_ADDR_RAW_RGB       32'h0000_0208

// audio options
`define PCE_ADDR_MASTER_BOOST  32'h0000_0300
`define PCE_ADDR_ADPCM_BOOST   32'h0000_0304
`define PCE_ADDR_CD_BOOST      32'h0000_0308

`define PCE_ADDR_ANALOGIZER    32'hF700_0000

// core reset stretch, short for simulation
`define PCE_RESET_HOLD         256
`define PCE_RESET_CNT_W        9

// analogizer word layout, bit 5 unused
`define PCE_SNAC_TYPE_LSB      0
`define PCE_SNAC_ASSIGN_LSB    6
`define PCE_VIDEO_TYPE_LSB     10

`endif
